// ==== Bender.yml ====
package:
  name: mandel_render

sources:
  - src/mandel_pkg.sv
  - src/row_scanner.sv
  - src/escape_iterator.sv
  - src/palette_out.sv
  - src/mandel_render.sv
  - target: simulation
    files:
      - bench/mandel_render_chk.sv
      - bench/mandel_render_tb.sv

// ==== bench/mandel_render_chk.sv ====
`timescale 1ns/1ps

module mandel_render_chk import mandel_pkg::*; (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input logic pix_credit,
	input logic [$clog2(PIX_CREDITS+1)-1:0] credits
);

	// Credits handed back by the sink since reset
	int unsigned returned;
	// Pixels sent since reset, one credit each
	int unsigned spent;
	// Failed assertions so far
	int unsigned fails;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			returned <= 0;
			spent <= 0;
		end else begin
			if (pix_credit)
				returned <= returned + 1;
			if (pix_valid)
				spent <= spent + 1;
		end
	end

	// No pixel leaves unless grant plus returns exceed what was spent
	assert property (@(posedge clk) disable iff (rst)
		pix_valid |-> (spent < PIX_CREDITS + returned))
		else begin
			$error("pix_valid raised with no pixel credit");
			fails++;
		end

	// Credits on hand never above grant plus returns less spending
	assert property (@(posedge clk) disable iff (rst)
		credits + spent <= PIX_CREDITS + returned)
		else begin
			$error("pixel credit count above granted credits");
			fails++;
		end

	// Quiet output in reset
	assert property (@(posedge clk) rst |-> !pix_valid)
		else begin
			$error("pix_valid high during reset");
			fails++;
		end

endmodule

bind palette_out mandel_render_chk u_chk (
	.clk(clk), .rst(rst), .pix_valid(pix_valid),
	.pix_credit(pix_credit), .credits(credits)
);

// ==== bench/mandel_render_tb.sv ====
`timescale 1ns/1ps

module mandel_render_tb import mandel_pkg::*; ();

	logic clk;
	logic rst;
	logic cmd_valid;
	fix_t cmd_re;
	fix_t cmd_im;
	len_t cmd_len;
	logic cmd_credit;
	logic pix_valid;
	iter_t pix_iter;
	color_t pix_color;
	logic pix_credit;

	// Trace contents
	fix_t tr_re [$];
	fix_t tr_im [$];
	len_t tr_len [$];
	int exp_iter [$];
	int exp_color [$];
	int exp_cmd [$];

	// Run state
	logic running;
	int cmd_idx, pix_idx, src_credits, credit_pulses, pix_avail, owed;
	int gap_left;
	int mismatches, proto_errors;
	logic [15:0] lfsr;

	mandel_render dut (.*);

	// 16-bit Galois LFSR, one step per bit taken
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Command source, pixel sink and checks
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		logic [4:0] gap_bits;
		if (running) begin
			// Returned command credit
			if (cmd_credit)
				credit_pulses++;
			src_credits = src_credits + cmd_credit;
			if (src_credits > CMD_DEPTH) begin
				$display("command credits returned beyond the buffer depth");
				proto_errors++;
			end
			if (cmd_idx < tr_re.size() && src_credits > 0) begin
				cmd_valid <= 1'b1;
				cmd_re <= tr_re[cmd_idx];
				cmd_im <= tr_im[cmd_idx];
				cmd_len <= tr_len[cmd_idx];
				src_credits--;
				cmd_idx++;
			end else begin
				cmd_valid <= 1'b0;
			end
			// Pixel arrival against the trace
			if (pix_valid) begin
				if (pix_avail == 0) begin
					$display("pixel arrived with no pixel credit left");
					proto_errors++;
				end
				if (pix_idx >= exp_iter.size()) begin
					$display("more pixels arrived than the trace holds");
					proto_errors++;
				end else begin
					if (pix_iter != exp_iter[pix_idx]) begin
						$display("mismatch iter cmd%0d_px%0d expected %0d actual %0d",
							exp_cmd[pix_idx], pix_idx, exp_iter[pix_idx], pix_iter);
						mismatches++;
					end
					if (pix_color != exp_color[pix_idx]) begin
						$display("mismatch color cmd%0d_px%0d expected %02h actual %02h",
							exp_cmd[pix_idx], pix_idx, exp_color[pix_idx], pix_color);
						mismatches++;
					end
				end
				pix_idx++;
			end
			pix_avail = pix_avail + pix_credit - pix_valid;
			owed = owed - pix_credit + pix_valid;
			// Credit goes back after 32 to 63 cycles with a pixel owed
			if (owed > 0 && gap_left > 1) begin
				gap_left--;
				pix_credit <= 1'b0;
			end else if (owed > 0) begin
				gap_bits = '0;
				for (int b = 0; b < 5; b++) begin
					lfsr = lfsr_next(lfsr);
					gap_bits = {gap_bits[3:0], lfsr[0]};
				end
				gap_left = 32 + gap_bits;
				pix_credit <= 1'b1;
			end else begin
				pix_credit <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Trace load, reset and end of run
	//////////////////////////////////////////////////////////////////////

	initial begin
		int fd, v_re, v_im, v_len, v_it, v_col, limit, cycles;
		string line;
		rst <= 1'b1;
		cmd_valid <= 1'b0;
		cmd_re <= '0;
		cmd_im <= '0;
		cmd_len <= '0;
		pix_credit <= 1'b0;
		running <= 1'b0;
		{cmd_idx, pix_idx, credit_pulses, owed, mismatches, proto_errors} = '0;
		src_credits = CMD_DEPTH;
		pix_avail = PIX_CREDITS;
		gap_left = 32;
		lfsr = 16'd98;
		limit = 500;
		fd = $fopen("bench/mandel_trace.txt", "r");
		if (fd == 0) begin
			$display("trace file bench/mandel_trace.txt could not be opened");
			proto_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line[0] == "C") begin
					void'($sscanf(line, "C %h %h %d", v_re, v_im, v_len));
					tr_re.push_back(fix_t'(v_re));
					tr_im.push_back(fix_t'(v_im));
					tr_len.push_back(len_t'(v_len));
				end else if (line.len() > 0 && line[0] == "P") begin
					void'($sscanf(line, "P %d %h", v_it, v_col));
					exp_iter.push_back(v_it);
					exp_color.push_back(v_col);
					exp_cmd.push_back(tr_re.size() - 1);
					// Longest credit gap plus pipeline overhead per pixel
					limit = limit + v_it + 80;
				end
			end
			$fclose(fd);
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		// Idle outputs before the first command
		repeat (8) begin
			@(posedge clk);
			if (pix_valid || cmd_credit) begin
				$display("pix_valid or cmd_credit high before any command");
				proto_errors++;
			end
		end
		running <= 1'b1;
		cycles = 0;
		while (pix_idx < exp_iter.size() && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (pix_idx < exp_iter.size()) begin
			$display("timeout after %0d cycles with %0d of %0d pixels received",
				cycles, pix_idx, exp_iter.size());
			$display("errors: %0d mismatches, %0d other", mismatches, proto_errors);
			$display("Result: FAILED");
		end else begin
			// Catch stray pixels or late credits
			repeat (40) @(negedge clk);
			if (credit_pulses != tr_re.size() || cmd_idx != tr_re.size()) begin
				$display("%0d command credits returned for %0d commands sent",
					credit_pulses, cmd_idx);
				proto_errors++;
			end
			if (exp_iter.size() == 0) begin
				$display("trace holds no pixels");
				proto_errors++;
			end
			if (dut.u_palette.u_chk.fails != 0) begin
				$display("%0d pixel credit assertions failed", dut.u_palette.u_chk.fails);
				proto_errors++;
			end
			$display("errors: %0d mismatches, %0d other", mismatches, proto_errors);
			if (mismatches == 0 && proto_errors == 0)
				$display("Result: PASSED");
			else
				$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== bench/mandel_trace.txt ====
# C re_hex im_hex len : row command, start point in signed 4.23 hex, pixel count
# P iter color_hex : expected iteration count and RGB332 colour of the next pixel
C 0000000 0000000 1
P 1000 00
C 1000000 0000000 1
P 2 52
C 023D70A 0000000 1
P 16 6A
C 0266666 0000000 1
P 12 52
C 0400000 0400000 1
P 5 52
C 0000000 0800000 1
P 1000 00
C 0800000 0000000 4
P 3 52
P 2 52
P 2 52
P 2 52
C 7000000 0000000 3
P 1000 00
P 1000 00
P 1000 00

// ==== build.f ====
src/mandel_pkg.sv
src/row_scanner.sv
src/escape_iterator.sv
src/palette_out.sv
src/mandel_render.sv
bench/mandel_render_chk.sv
bench/mandel_render_tb.sv

// ==== src/escape_iterator.sv ====
`timescale 1ns/1ps

module escape_iterator import mandel_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic pt_valid,
	input  fix_t pt_re,
	input  fix_t pt_im,
	output logic iter_ready,
	input  logic res_ready,
	output logic res_valid,
	output iter_t res_iter
);

	iter_state_t state;
	// Point and orbit
	fix_t cr;
	fix_t ci;
	fix_t zr;
	fix_t zi;
	iter_t n;

	// Per-cycle arithmetic
	mag_t zr_sq;
	mag_t zi_sq;
	mag_t mag_sum;
	fix_t zri;
	fix_t zr_next;
	fix_t zi_next;
	logic escaped;
	logic finish;

	// Full signed product scaled back to 23 fraction bits
	function automatic logic signed [2*$bits(fix_t)-1:0] fx_mul(input fix_t a, input fix_t b);
		logic signed [2*$bits(fix_t)-1:0] prod;
		prod = a * b;
		return prod >>> FRAC_BITS;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// z squared plus c
	//////////////////////////////////////////////////////////////////////

	// Three multipliers, each truncated to its destination
	assign zr_sq = mag_t'(fx_mul(zr, zr));
	assign zi_sq = mag_t'(fx_mul(zi, zi));
	assign zri = fix_t'(fx_mul(zr, zi));

	assign mag_sum = zr_sq + zi_sq;
	assign escaped = mag_sum > ESCAPE_MAG;
	// Stop on escape or at the limit
	assign finish = escaped || (n == MAX_ITER);

	// Squares are at most 4.0 whenever z is updated
	assign zr_next = fix_t'(zr_sq) - fix_t'(zi_sq) + cr;
	assign zi_next = (zri <<< 1) + ci;

	assign iter_ready = (state == ITER_IDLE);
	assign res_valid = (state == ITER_HOLD) && res_ready;
	assign res_iter = n;

	// Control FSM and iteration count
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ITER_IDLE;
			n <= '0;
		end else if (pt_valid) begin
			// Scanner only offers a point while idle
			state <= ITER_CALC;
			n <= '0;
		end else begin
			case (state)
				ITER_IDLE: state <= ITER_IDLE;
				ITER_CALC: begin
					if (finish)
						state <= ITER_HOLD;
					else
						n <= n + 1'b1;
				end
				// Count stays put until the output side has room
				ITER_HOLD: begin
					if (res_ready)
						state <= ITER_IDLE;
				end
				default: state <= ITER_IDLE;
			endcase
		end
	end

	// Orbit registers
	always_ff @(posedge clk) begin
		if (pt_valid) begin
			cr <= pt_re;
			ci <= pt_im;
			zr <= '0;
			zi <= '0;
		end else if ((state == ITER_CALC) && !finish) begin
			zr <= zr_next;
			zi <= zi_next;
		end
	end

endmodule

// ==== src/mandel_pkg.sv ====
package mandel_pkg;

	//////////////////////////////////////////////////////////////////////
	// Fixed-point formats and sizes
	//////////////////////////////////////////////////////////////////////

	localparam int FRAC_BITS = 23;
	localparam int ROW_MAX = 64;

	// Signed 4.23, used for c and z
	typedef logic signed [26:0] fix_t;
	// Unsigned 9.23 for squares and their sum
	typedef logic [31:0] mag_t;
	typedef logic [9:0] iter_t;
	// RGB332, red in the top three bits
	typedef logic [7:0] color_t;
	// Pixels per row command, 1 to ROW_MAX
	typedef logic [$clog2(ROW_MAX+1)-1:0] len_t;

	// Iteration limit and escape bound (4.0)
	localparam iter_t MAX_ITER = 10'd1000;
	localparam mag_t ESCAPE_MAG = 32'h0200_0000;
	// Real step per pixel, roughly 3/640
	localparam fix_t STEP_RE = 27'sd39321;

	// Buffer depths and initial credits
	localparam int CMD_DEPTH = 2;
	localparam int OUT_DEPTH = 2;
	localparam int PIX_CREDITS = 4;

	//////////////////////////////////////////////////////////////////////
	// Threshold palette
	//////////////////////////////////////////////////////////////////////

	// Entry k applies from MAX_ITER >> k upward, entry 0 is the set itself
	localparam int PAL_BANDS = 8;
	localparam color_t PAL_COLOR [0:PAL_BANDS] = '{
		8'b000_000_00, 8'b011_001_00, 8'b011_001_00,
		8'b101_010_01, 8'b011_001_01, 8'b001_001_01,
		8'b011_010_10, 8'b010_100_10, 8'b010_100_10
	};
	// Counts below the last band
	localparam color_t PAL_DEFAULT = 8'b010_100_10;

	// Scanner and iterator states
	typedef enum logic {SCAN_IDLE, SCAN_ISSUE} scan_state_t;
	typedef enum logic [1:0] {ITER_IDLE, ITER_CALC, ITER_HOLD} iter_state_t;

endpackage

// ==== src/mandel_render.sv ====
`timescale 1ns/1ps

module mandel_render import mandel_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic cmd_valid,
	input  fix_t cmd_re,
	input  fix_t cmd_im,
	input  len_t cmd_len,
	output logic cmd_credit,
	output logic pix_valid,
	output iter_t pix_iter,
	output color_t pix_color,
	input  logic pix_credit
);

	// Scanner to iterator
	logic iter_ready;
	logic pt_valid;
	fix_t pt_re;
	fix_t pt_im;

	// Iterator to palette
	logic res_ready;
	logic res_valid;
	iter_t res_iter;

	//////////////////////////////////////////////////////////////////////
	// Pipeline stages in order
	//////////////////////////////////////////////////////////////////////

	row_scanner u_scanner (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd_re(cmd_re), .cmd_im(cmd_im), .cmd_len(cmd_len),
		.cmd_credit(cmd_credit), .iter_ready(iter_ready),
		.pt_valid(pt_valid), .pt_re(pt_re), .pt_im(pt_im)
	);

	escape_iterator u_iterator (
		.clk(clk), .rst(rst),
		.pt_valid(pt_valid), .pt_re(pt_re), .pt_im(pt_im), .iter_ready(iter_ready),
		.res_ready(res_ready), .res_valid(res_valid), .res_iter(res_iter)
	);

	palette_out u_palette (
		.clk(clk), .rst(rst),
		.res_valid(res_valid), .res_iter(res_iter), .res_ready(res_ready),
		.pix_credit(pix_credit),
		.pix_valid(pix_valid), .pix_iter(pix_iter), .pix_color(pix_color)
	);

endmodule

// ==== src/palette_out.sv ====
`timescale 1ns/1ps

module palette_out import mandel_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic res_valid,
	input  iter_t res_iter,
	output logic res_ready,
	input  logic pix_credit,
	output logic pix_valid,
	output iter_t pix_iter,
	output color_t pix_color
);

	typedef logic [$clog2(PIX_CREDITS+1)-1:0] credit_t;

	// Result buffer
	iter_t out_buf [OUT_DEPTH];
	logic [$clog2(OUT_DEPTH)-1:0] wr_ptr;
	logic [$clog2(OUT_DEPTH)-1:0] rd_ptr;
	logic [$clog2(OUT_DEPTH+1)-1:0] out_count;
	// Sink credits on hand
	credit_t credits;

	assign res_ready = out_count < OUT_DEPTH;
	// Head leaves only with a credit
	assign pix_valid = (out_count != '0) && (credits != '0);
	assign pix_iter = out_buf[rd_ptr];

	//////////////////////////////////////////////////////////////////////
	// Threshold palette
	//////////////////////////////////////////////////////////////////////

	// Narrower bands first, higher thresholds override
	always_comb begin
		pix_color = PAL_DEFAULT;
		for (int k = PAL_BANDS; k >= 1; k--) begin
			if (pix_iter >= (MAX_ITER >> k))
				pix_color = PAL_COLOR[k];
		end
		// Points that never escaped
		if (pix_iter >= MAX_ITER)
			pix_color = PAL_COLOR[0];
	end

	// Buffer pointers, fill count and credits
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			out_count <= '0;
			credits <= credit_t'(PIX_CREDITS);
		end else begin
			if (res_valid)
				wr_ptr <= (wr_ptr == OUT_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pix_valid)
				rd_ptr <= (rd_ptr == OUT_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({res_valid, pix_valid})
				2'b10: out_count <= out_count + 1'b1;
				2'b01: out_count <= out_count - 1'b1;
				default: out_count <= out_count;
			endcase
			// Returned credit and spent credit may cancel
			case ({pix_credit, pix_valid})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Count storage
	always_ff @(posedge clk) begin
		if (res_valid)
			out_buf[wr_ptr] <= res_iter;
	end

endmodule

// ==== src/row_scanner.sv ====
`timescale 1ns/1ps

module row_scanner import mandel_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic cmd_valid,
	input  fix_t cmd_re,
	input  fix_t cmd_im,
	input  len_t cmd_len,
	output logic cmd_credit,
	input  logic iter_ready,
	output logic pt_valid,
	output fix_t pt_re,
	output fix_t pt_im
);

	// Command buffer, one slot per source credit
	fix_t buf_re [CMD_DEPTH];
	fix_t buf_im [CMD_DEPTH];
	len_t buf_len [CMD_DEPTH];
	logic [$clog2(CMD_DEPTH)-1:0] wr_ptr;
	logic [$clog2(CMD_DEPTH)-1:0] rd_ptr;
	logic [$clog2(CMD_DEPTH+1)-1:0] cmd_count;

	// Row being scanned
	scan_state_t state;
	fix_t cur_re;
	fix_t cur_im;
	len_t remain;
	// Head command moves into the scan registers
	logic load;

	assign load = (state == SCAN_IDLE) && (cmd_count != '0);

	// One point per free iterator
	assign pt_valid = (state == SCAN_ISSUE) && iter_ready;
	assign pt_re = cur_re;
	assign pt_im = cur_im;
	// Credit goes back with the last pixel of the row
	assign cmd_credit = pt_valid && (remain == len_t'(1));

	//////////////////////////////////////////////////////////////////////
	// Buffer pointers and fill count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cmd_count <= '0;
		end else begin
			if (cmd_valid)
				wr_ptr <= (wr_ptr == CMD_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (load)
				rd_ptr <= (rd_ptr == CMD_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({cmd_valid, load})
				2'b10: cmd_count <= cmd_count + 1'b1;
				2'b01: cmd_count <= cmd_count - 1'b1;
				default: cmd_count <= cmd_count;
			endcase
		end
	end

	// Scan FSM and pixel countdown
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= SCAN_IDLE;
			remain <= '0;
		end else begin
			case (state)
				SCAN_IDLE: begin
					if (load) begin
						state <= SCAN_ISSUE;
						remain <= buf_len[rd_ptr];
					end
				end
				SCAN_ISSUE: begin
					if (pt_valid) begin
						remain <= remain - 1'b1;
						if (remain == len_t'(1))
							state <= SCAN_IDLE;
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	// Buffer storage and point registers
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			buf_re[wr_ptr] <= cmd_re;
			buf_im[wr_ptr] <= cmd_im;
			buf_len[wr_ptr] <= cmd_len;
		end
		// Step along the real axis after each issued point
		if (load) begin
			cur_re <= buf_re[rd_ptr];
			cur_im <= buf_im[rd_ptr];
		end else if (pt_valid) begin
			cur_re <= cur_re + STEP_RE;
		end
	end

endmodule
